// ==== uart_frame_macros.svh ====
/*
 * Build-time constants for the UART string link.
 * FRAME_CLK_FREQ must be a whole multiple of FRAME_BAUD_RATE, and the
 * baud rate cannot be changed at run time.
 */
`ifndef UART_FRAME_MACROS_SVH
`define UART_FRAME_MACROS_SVH

// system clock in Hz
`define FRAME_CLK_FREQ     10_000_000

// serial line rate in bit/s
`define FRAME_BAUD_RATE    1_000_000

// sys_clk cycles per line bit
`define FRAME_CLKS_PER_BIT (`FRAME_CLK_FREQ / `FRAME_BAUD_RATE)

// longest payload in bytes, markers not counted
`define FRAME_MAX_LEN      137

`endif

// ==== uart_frame_pkg.sv ====
/*
 * Types shared by the frame blocks.
 * str_t is sized by FRAME_MAX_LEN, and element 0 is the first byte on the line.
 * The payload must not contain the marker character.
 */
`include "uart_frame_macros.svh"

package uart_frame_pkg;

	// one line character
	typedef logic [7:0] byte_t;

	// payload length in bytes, 0 to FRAME_MAX_LEN
	typedef logic [7:0] len_t;

	// whole payload, element 0 sent first
	typedef byte_t [`FRAME_MAX_LEN-1:0] str_t;

	// frame delimiter, two of them open a frame and two close it
	localparam byte_t FRAME_MARK = 8'h26;

endpackage

// ==== uart_tx.sv ====
/*
 * Byte serializer for 8 data bits, no parity, 2 stop bits, LSB first.
 * The line idles high. byte_start is taken only while idle, and byte_done
 * pulses in the last cycle of the second stop bit.
 */
`include "uart_frame_macros.svh"

module uart_tx (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  uart_frame_pkg::byte_t byte_data,
	input  logic                  byte_start,
	output logic                  byte_done,
	output logic                  uart_tx_port
);
	import uart_frame_pkg::*;

	localparam int unsigned CLKS_PER_BIT = `FRAME_CLKS_PER_BIT;
	localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);
	// start bit, 8 data bits, then stop bits 9 and 10
	localparam logic [3:0]  LAST_BIT     = 4'd10;

	logic             busy;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_idx;
	byte_t            shift_reg;
	logic             bit_end;

	assign bit_end   = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign byte_done = busy && bit_end && (bit_idx == LAST_BIT);

	// baud timing and line driver
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy         <= 1'b0;
			baud_cnt     <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;
		end else if (!busy) begin
			baud_cnt <= '0;
			bit_idx  <= '0;
			if (byte_start) begin
				busy         <= 1'b1;
				// start bit
				uart_tx_port <= 1'b0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_idx == LAST_BIT) begin
				busy <= 1'b0;
			end else begin
				bit_idx      <= bit_idx + 4'd1;
				uart_tx_port <= shift_reg[0];
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// ones shift in behind the data so the stop bits come out on their own
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_start) begin
			shift_reg <= byte_data;
		end else if (busy && bit_end) begin
			shift_reg <= {1'b1, shift_reg[7:1]};
		end
	end

	// the sequencer has to wait for byte_done before the next byte
	a_no_start_while_busy: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) byte_start |-> !busy
	) else $error("uart_tx: byte_start while a byte is in progress");

endmodule

// ==== uart_rx.sv ====
/*
 * Byte deserializer for 8 data bits, no parity, one stop bit, LSB first.
 * Bits are sampled at mid-bit after a two-flop synchronizer.
 * A byte with a low stop bit is dropped without notice.
 * rx_byte is only meaningful in the rx_valid cycle.
 */
`include "uart_frame_macros.svh"

module uart_rx (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  uart_rx_port,
	output uart_frame_pkg::byte_t rx_byte,
	output logic                  rx_valid
);
	import uart_frame_pkg::*;

	localparam int unsigned CLKS_PER_BIT = `FRAME_CLKS_PER_BIT;
	localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_last;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	byte_t            shift_reg;
	logic             start_edge;
	logic             bit_end;
	logic             half_end;

	// line idles high, so the flops reset to one
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	assign start_edge = rx_last && !rx_sync;
	assign bit_end    = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign half_end   = (baud_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));

	// valid at the middle of a high stop bit
	assign rx_valid = (state == st_stop) && bit_end && rx_sync;
	assign rx_byte  = shift_reg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= st_idle;
			baud_cnt <= '0;
			bit_idx  <= '0;
		end else begin
			case (state)
				st_idle: begin
					baud_cnt <= '0;
					bit_idx  <= '0;
					if (start_edge) begin
						state <= st_start;
					end
				end
				st_start: begin
					if (half_end) begin
						baud_cnt <= '0;
						// glitch shorter than half a bit
						state    <= rx_sync ? st_idle : st_data;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				st_data: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= st_stop;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				st_stop: begin
					if (bit_end) begin
						baud_cnt <= '0;
						state    <= st_idle;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == st_data && bit_end) begin
			shift_reg <= {rx_sync, shift_reg[7:1]};
		end
	end

	a_valid_single: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) rx_valid |=> !rx_valid
	) else $error("uart_rx: rx_valid held for two cycles");

endmodule

// ==== frame_tx.sv ====
/*
 * Sends tx_string as "&&payload&&" one byte at a time through uart_tx.
 * tx_req is ignored while tx_busy is high, and tx_string and tx_length
 * must stay stable until tx_done. A '&' in the payload goes out unchanged.
 */
`include "uart_frame_macros.svh"

module frame_tx (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  uart_frame_pkg::str_t  tx_string,
	input  uart_frame_pkg::len_t  tx_length,
	input  logic                  tx_req,
	input  logic                  byte_done,
	output uart_frame_pkg::byte_t byte_data,
	output logic                  byte_start,
	output logic                  tx_busy,
	output logic                  tx_done
);
	import uart_frame_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_mark1,
		st_mark2,
		st_content,
		st_close1,
		st_close2,
		st_finish
	} tx_state_t;

	tx_state_t state;
	len_t      byte_idx;
	logic      accept;

	// finish is the tx_done cycle, a new request may start there
	assign tx_busy = (state != st_idle) && (state != st_finish);
	assign tx_done = (state == st_finish);
	assign accept  = tx_req && !tx_busy;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= st_idle;
			byte_idx   <= '0;
			byte_data  <= '0;
			byte_start <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			case (state)
				st_idle, st_finish: begin
					state <= st_idle;
					if (accept) begin
						state      <= st_mark1;
						byte_idx   <= '0;
						byte_data  <= FRAME_MARK;
						byte_start <= 1'b1;
					end
				end
				st_mark1: begin
					if (byte_done) begin
						state      <= st_mark2;
						byte_data  <= FRAME_MARK;
						byte_start <= 1'b1;
					end
				end
				st_mark2: begin
					if (byte_done) begin
						byte_start <= 1'b1;
						// empty payload goes straight to the closing pair
						if (tx_length == '0) begin
							state     <= st_close1;
							byte_data <= FRAME_MARK;
						end else begin
							state     <= st_content;
							byte_data <= tx_string[0];
							byte_idx  <= len_t'(1);
						end
					end
				end
				st_content: begin
					if (byte_done) begin
						byte_start <= 1'b1;
						if (byte_idx == tx_length) begin
							state     <= st_close1;
							byte_data <= FRAME_MARK;
						end else begin
							byte_data <= tx_string[byte_idx];
							byte_idx  <= byte_idx + 1'b1;
						end
					end
				end
				st_close1: begin
					if (byte_done) begin
						state      <= st_close2;
						byte_data  <= FRAME_MARK;
						byte_start <= 1'b1;
					end
				end
				st_close2: begin
					if (byte_done) begin
						state <= st_finish;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	a_len_in_range: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		accept |-> (tx_length <= len_t'(`FRAME_MAX_LEN))
	) else $error("frame_tx: tx_length above FRAME_MAX_LEN");

	// the last byte must be fully on the line before tx_done
	a_done_not_start: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) !(tx_done && byte_start)
	) else $error("frame_tx: tx_done together with byte_start");

endmodule

// ==== frame_rx.sv ====
/*
 * Finds "&&payload&&" frames in the received byte stream.
 * Non-marker bytes between frames are ignored. A broken frame or a payload
 * longer than FRAME_MAX_LEN gives rx_error and keeps the last good result.
 * A '&' inside the payload is taken as the first closing marker.
 */
`include "uart_frame_macros.svh"

module frame_rx (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  uart_frame_pkg::byte_t rx_byte,
	input  logic                  rx_valid,
	output uart_frame_pkg::str_t  rx_string,
	output uart_frame_pkg::len_t  rx_length,
	output logic                  rx_busy,
	output logic                  rx_done,
	output logic                  rx_error
);
	import uart_frame_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_one_mark,
		st_content,
		st_close_one,
		st_close_two
	} rx_state_t;

	rx_state_t state;
	str_t      work_buf;
	str_t      clean_buf;
	len_t      work_len;
	logic      is_mark;
	logic      buf_full;

	assign is_mark  = (rx_byte == FRAME_MARK);
	assign buf_full = (work_len == len_t'(`FRAME_MAX_LEN));

	// close_two lasts one cycle and is the done strobe
	assign rx_done = (state == st_close_two);
	assign rx_busy = (state != st_idle) && (state != st_close_two);

	// stale bytes above the count are zeroed on the way out
	always_comb begin
		for (int i = 0; i < `FRAME_MAX_LEN; i++) begin
			clean_buf[i] = (len_t'(i) < work_len) ? work_buf[i] : '0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= st_idle;
			work_len  <= '0;
			rx_error  <= 1'b0;
			rx_length <= '0;
			rx_string <= '0;
		end else begin
			rx_error <= 1'b0;
			case (state)
				st_idle, st_close_two: begin
					state <= (rx_valid && is_mark) ? st_one_mark : st_idle;
				end
				st_one_mark: begin
					if (rx_valid) begin
						if (is_mark) begin
							state    <= st_content;
							work_len <= '0;
						end else begin
							state    <= st_idle;
							rx_error <= 1'b1;
						end
					end
				end
				st_content: begin
					if (rx_valid) begin
						if (is_mark) begin
							state <= st_close_one;
						end else if (buf_full) begin
							// overflow drops the whole frame
							state    <= st_idle;
							rx_error <= 1'b1;
						end else begin
							work_len <= work_len + 1'b1;
						end
					end
				end
				st_close_one: begin
					if (rx_valid) begin
						if (is_mark) begin
							state     <= st_close_two;
							rx_length <= work_len;
							rx_string <= clean_buf;
						end else begin
							state    <= st_idle;
							rx_error <= 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// working buffer
	always_ff @(posedge sys_clk) begin
		if (state == st_content && rx_valid && !is_mark && !buf_full) begin
			work_buf[work_len] <= rx_byte;
		end
	end

	a_done_error_excl: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) !(rx_done && rx_error)
	) else $error("frame_rx: rx_done and rx_error together");

endmodule

// ==== uart_frame_top.sv ====
/*
 * UART string link top level with one serial pin each way.
 * Transmit and receive run independently, and neither side has back-pressure.
 */
module uart_frame_top (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_frame_pkg::str_t tx_string,
	input  uart_frame_pkg::len_t tx_length,
	input  logic                 tx_req,
	output logic                 tx_busy,
	output logic                 tx_done,
	output uart_frame_pkg::str_t rx_string,
	output uart_frame_pkg::len_t rx_length,
	output logic                 rx_busy,
	output logic                 rx_done,
	output logic                 rx_error,
	input  logic                 uart_rx_port,
	output logic                 uart_tx_port
);
	import uart_frame_pkg::*;

	// transmit side
	byte_t byte_data;
	logic  byte_start;
	logic  byte_done;

	// receive side
	byte_t rx_byte;
	logic  rx_valid;

	uart_rx u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

	frame_tx u_frame_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.byte_done  (byte_done),
		.byte_data  (byte_data),
		.byte_start (byte_start),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done)
	);

	uart_tx u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_data    (byte_data),
		.byte_start   (byte_start),
		.byte_done    (byte_done),
		.uart_tx_port (uart_tx_port)
	);

endmodule

// ==== tb_uart_frame.sv ====
/*
 * Testbench for uart_frame_top. Loopback frames cover both paths, and a serial
 * driver feeds garbage and broken frames into the receiver.
 * All timeouts count sys_clk cycles.
 */
`include "uart_frame_macros.svh"

module tb_uart_frame;
	timeunit 1ns;
	timeprecision 1ps;
	import uart_frame_pkg::*;

	localparam int CLKS        = `FRAME_CLKS_PER_BIT;
	localparam int MAX_LEN     = `FRAME_MAX_LEN;
	localparam int CHAR_CYCLES = 11 * CLKS;
	localparam int FRAME_TMO   = 2 * (MAX_LEN + 4) * CHAR_CYCLES;
	localparam int EV_TX_DONE  = 0;
	localparam int EV_RX_DONE  = 1;
	localparam int EV_RX_ERR   = 2;

	logic        sys_clk;
	logic        sys_rst_n;
	str_t        tx_string;
	len_t        tx_length;
	logic        tx_req;
	logic        tx_busy;
	logic        tx_done;
	str_t        rx_string;
	len_t        rx_length;
	logic        rx_busy;
	logic        rx_done;
	logic        rx_error;
	logic        uart_rx_port;
	logic        uart_tx_port;

	// 1 selects loopback as the serial source
	logic        loop_sel;
	logic        ser_line;
	logic [31:0] lfsr;
	str_t        exp_str;
	len_t        exp_len;
	logic        err_allowed;
	int          ev_cnt [3];
	byte_t       ser_q [$];

	assign uart_rx_port = loop_sel ? uart_tx_port : ser_line;

	uart_frame_top DUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		fail_run($sformatf("ERR %s exp 0x%0h got 0x%0h", name, exp, got));
	endtask

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = galois_step(lfsr);
			v    = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	// marker never appears inside a payload
	function automatic byte_t random_payload_byte();
		byte_t b;
		b = take_bits(8);
		return (b == FRAME_MARK) ? 8'h41 : b;
	endfunction

	task automatic check_idle_outputs();
		assert (tx_busy === 1'b0) else report_value("tx_busy", 0, tx_busy);
		assert (tx_done === 1'b0) else report_value("tx_done", 0, tx_done);
		assert (rx_busy === 1'b0) else report_value("rx_busy", 0, rx_busy);
		assert (rx_done === 1'b0) else report_value("rx_done", 0, rx_done);
		assert (rx_error === 1'b0) else report_value("rx_error", 0, rx_error);
		assert (uart_tx_port === 1'b1) else report_value("uart_tx_port", 1, uart_tx_port);
		assert (rx_length === 8'h00) else report_value("rx_length", 0, rx_length);
	endtask

	// bytes below the length must match and the rest must be zero
	task automatic check_result();
		byte_t exp_b;
		assert (rx_length === exp_len) else report_value("rx_length", exp_len, rx_length);
		for (int i = 0; i < MAX_LEN; i++) begin
			exp_b = (i < exp_len) ? exp_str[i] : 8'h00;
			assert (rx_string[i] === exp_b)
				else report_value($sformatf("rx_string[%0d]", i), exp_b, rx_string[i]);
		end
	endtask

	task automatic check_count(input string name, input int idx, input int exp);
		assert (ev_cnt[idx] == exp) else report_value(name, exp, ev_cnt[idx]);
	endtask

	task automatic wait_count(input int idx, input int target, input string what);
		int waited;
		waited = 0;
		while (ev_cnt[idx] < target) begin
			if (waited == FRAME_TMO) begin
				fail_run($sformatf("timeout waiting for %s", what));
			end
			@(posedge sys_clk);
			waited++;
		end
	endtask

	// strobe monitor with counters that move on the clock edge
	always @(posedge sys_clk) begin
		if (sys_rst_n) begin
			if (tx_done) begin
				ev_cnt[EV_TX_DONE] <= ev_cnt[EV_TX_DONE] + 1;
			end
			if (rx_done) begin
				ev_cnt[EV_RX_DONE] <= ev_cnt[EV_RX_DONE] + 1;
				check_result();
			end
			if (rx_error) begin
				assert (err_allowed)
					else fail_run("rx_error on a frame that should be accepted");
				ev_cnt[EV_RX_ERR] <= ev_cnt[EV_RX_ERR] + 1;
				// last good result must survive a dropped frame
				check_result();
			end
		end
	end

	a_busy_after_req: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) (tx_req && !tx_busy) |=> tx_busy
	) else fail_run("tx_busy did not rise after an accepted tx_req");

	a_busy_needs_req: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) $rose(tx_busy) |-> $past(tx_req)
	) else fail_run("tx_busy rose without a tx_req");

	a_done_on_fall: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) tx_done |-> (!tx_busy && $past(tx_busy))
	) else fail_run("tx_done did not coincide with tx_busy falling");

	a_fall_gives_done: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) $fell(tx_busy) |-> tx_done
	) else fail_run("tx_busy fell without tx_done");

	a_done_single: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) tx_done |=> !tx_done
	) else fail_run("tx_done lasted more than one cycle");

	a_rx_excl: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) !(rx_done && rx_error)
	) else fail_run("rx_done and rx_error high in the same cycle");

	a_rx_idle_after: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) (rx_done || rx_error) |=> !rx_busy
	) else fail_run("rx_busy high in the cycle after rx_done or rx_error");

	task automatic run_loopback_frame(input int len, input bit poke_while_busy);
		str_t s;
		int   base_tx;
		int   base_rx;
		int   base_err;
		s = '0;
		for (int i = 0; i < len; i++) begin
			s[i] = random_payload_byte();
		end
		base_tx  = ev_cnt[EV_TX_DONE];
		base_rx  = ev_cnt[EV_RX_DONE];
		base_err = ev_cnt[EV_RX_ERR];
		@(posedge sys_clk);
		exp_str   <= s;
		exp_len   <= len_t'(len);
		tx_string <= s;
		tx_length <= len_t'(len);
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		if (poke_while_busy) begin
			// must be ignored while the frame is on the line
			repeat (3 * CLKS) @(posedge sys_clk);
			tx_req <= 1'b1;
			@(posedge sys_clk);
			tx_req <= 1'b0;
		end
		wait_count(EV_RX_DONE, base_rx + 1, "rx_done of a loopback frame");
		wait_count(EV_TX_DONE, base_tx + 1, "tx_done of a loopback frame");
		repeat (2 * CHAR_CYCLES) @(posedge sys_clk);
		check_count("tx_done count", EV_TX_DONE, base_tx + 1);
		check_count("rx_done count", EV_RX_DONE, base_rx + 1);
		check_count("rx_error count", EV_RX_ERR, base_err);
	endtask

	// 8N1 at the line rate
	task automatic send_serial_byte(input byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			ser_line <= bits[i];
			repeat (CLKS - 1) @(posedge sys_clk);
		end
	endtask

	task automatic push_text(input string s);
		for (int i = 0; i < s.len(); i++) begin
			ser_q.push_back(byte_t'(s[i]));
		end
	endtask

	task automatic send_queue();
		byte_t b;
		while (ser_q.size() > 0) begin
			b = ser_q.pop_front();
			send_serial_byte(b);
		end
	endtask

	task automatic run_driver_frame();
		str_t s;
		int   base_rx;
		int   base_err;
		s = '0;
		for (int i = 0; i < 5; i++) begin
			s[i] = random_payload_byte();
		end
		base_rx  = ev_cnt[EV_RX_DONE];
		base_err = ev_cnt[EV_RX_ERR];
		@(posedge sys_clk);
		exp_str <= s;
		exp_len <= len_t'(5);
		// garbage ahead of the frame
		push_text("q7&&");
		for (int i = 0; i < 5; i++) begin
			ser_q.push_back(s[i]);
		end
		push_text("&&");
		send_queue();
		wait_count(EV_RX_DONE, base_rx + 1, "rx_done after garbage bytes");
		repeat (2 * CHAR_CYCLES) @(posedge sys_clk);
		check_count("rx_done count", EV_RX_DONE, base_rx + 1);
		check_count("rx_error count", EV_RX_ERR, base_err);
	endtask

	task automatic expect_dropped(input string what);
		int base_rx;
		int base_err;
		base_rx  = ev_cnt[EV_RX_DONE];
		base_err = ev_cnt[EV_RX_ERR];
		@(posedge sys_clk);
		err_allowed <= 1'b1;
		send_queue();
		wait_count(EV_RX_ERR, base_err + 1, what);
		repeat (2 * CHAR_CYCLES) @(posedge sys_clk);
		err_allowed <= 1'b0;
		check_count("rx_error count", EV_RX_ERR, base_err + 1);
		check_count("rx_done count", EV_RX_DONE, base_rx);
	endtask

	initial begin
		sys_rst_n   = 1'b0;
		tx_string   = '0;
		tx_length   = '0;
		tx_req      = 1'b0;
		loop_sel    = 1'b1;
		ser_line    = 1'b1;
		lfsr        = 32'h860b_cc6a;
		exp_str     = '0;
		exp_len     = '0;
		err_allowed = 1'b0;
		foreach (ev_cnt[i]) begin
			ev_cnt[i] = 0;
		end

		// outputs settle after the first edge in reset
		for (int i = 0; i < 16; i++) begin
			@(posedge sys_clk);
			if (i > 0) begin
				check_idle_outputs();
			end
		end
		sys_rst_n <= 1'b1;
		repeat (2) begin
			@(posedge sys_clk);
			check_idle_outputs();
		end

		run_loopback_frame(1, 1'b0);
		run_loopback_frame(MAX_LEN, 1'b0);
		run_loopback_frame(1 + (take_bits(8) % MAX_LEN), 1'b1);
		repeat (3) run_loopback_frame(1 + (take_bits(8) % MAX_LEN), 1'b0);
		run_loopback_frame(0, 1'b0);

		@(posedge sys_clk);
		loop_sel <= 1'b0;
		run_driver_frame();
		push_text("&x");
		expect_dropped("rx_error on a single opening marker");
		push_text("&&ab&z");
		expect_dropped("rx_error on a broken closing marker");
		push_text("&&");
		for (int i = 0; i <= MAX_LEN; i++) begin
			ser_q.push_back(random_payload_byte());
		end
		expect_dropped("rx_error on payload overflow");

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
uart_frame_pkg.sv
uart_tx.sv
uart_rx.sv
frame_tx.sv
frame_rx.sv
uart_frame_top.sv
tb_uart_frame.sv

// ==== Bender.yml ====
package:
  name: uart_frame

export_include_dirs:
  - .

sources:
  - uart_frame_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - frame_tx.sv
  - frame_rx.sv
  - uart_frame_top.sv
  - target: test
    files:
      - tb_uart_frame.sv
